/* mips_mem_pkg.sv */
package mips_mem_pkg;

    // ##############################
    // memory opcodes (major opcode field)
    // ##############################
    localparam logic [5:0] OP_LB  = 6'b100000;
    localparam logic [5:0] OP_LH  = 6'b100001;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_LBU = 6'b100100;
    localparam logic [5:0] OP_LHU = 6'b100101;
    localparam logic [5:0] OP_SB  = 6'b101000;
    localparam logic [5:0] OP_SH  = 6'b101001;
    localparam logic [5:0] OP_SW  = 6'b101011;

    // ##############################
    // exception vector bit positions
    // ##############################
    // bits 1:0 come from the memory stage, the rest from upstream
    localparam int EXC_BIT_ADES   = 0;
    localparam int EXC_BIT_ADEL   = 1;
    localparam int EXC_BIT_OV     = 2;
    localparam int EXC_BIT_SYS    = 3;
    localparam int EXC_BIT_BRK    = 4;
    localparam int EXC_BIT_RI     = 5;
    localparam int EXC_BIT_IFADEL = 6;
    localparam int EXC_BIT_INT    = 7;

    // cp0 cause.exccode values
    localparam int EXC_CODE_W = 5;
    localparam logic [EXC_CODE_W-1:0] EXC_INT  = 5'd0;
    localparam logic [EXC_CODE_W-1:0] EXC_ADEL = 5'd4;
    localparam logic [EXC_CODE_W-1:0] EXC_ADES = 5'd5;
    localparam logic [EXC_CODE_W-1:0] EXC_SYS  = 5'd8;
    localparam logic [EXC_CODE_W-1:0] EXC_BP   = 5'd9;
    localparam logic [EXC_CODE_W-1:0] EXC_RI   = 5'd10;
    localparam logic [EXC_CODE_W-1:0] EXC_OV   = 5'd12;

    // data ram word address width
    localparam int DMEM_AW = 8;

    // one memory word, seen as bytes, halfwords or a word
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
        logic [31:0]      w;
    } mem_word_u;

endpackage

/* sram_if.sv */
interface sram_if;

    logic        en;
    logic [3:0]  wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    // valid in the same cycle as addr
    logic [31:0] rdata;

    // memory stage side
    modport master (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    // ram side
    modport slave (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* mem_access.sv */
module mem_access (
    input  logic [5:0]  op,
    input  logic        mem_en,
    input  logic [31:0] mem_wdata,
    input  logic [31:0] mem_addr,
    input  logic [7:0]  except_in,
    output logic [31:0] mem_rdata,
    output logic [7:0]  except_out,
    sram_if.master      sram
);
    import mips_mem_pkg::*;

    logic        adel;
    logic        ades;
    mem_word_u   rd_word;
    mem_word_u   wr_word;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // ##############################
    // exception merge and sram control
    // ##############################
    always_comb begin
        except_out = except_in;
        except_out[EXC_BIT_ADEL] = adel;
        except_out[EXC_BIT_ADES] = ades;
    end

    // any pending exception kills the access
    assign sram.en    = mem_en && (except_out == 8'd0);
    assign sram.addr  = mem_addr;
    assign sram.wdata = wr_word.w;

    // load lanes
    assign rd_word = sram.rdata;
    assign ld_byte = rd_word.b[mem_addr[1:0]];
    assign ld_half = rd_word.h[mem_addr[1]];

    // ##############################
    // per-opcode formatting
    // ##############################
    always_comb begin
        adel      = 1'b0;
        ades      = 1'b0;
        sram.wen  = 4'b0000;
        wr_word.w = 32'd0;
        mem_rdata = 32'd0;
        case (op)
            OP_LW: begin
                if (mem_addr[1:0] != 2'b00) begin
                    adel = 1'b1;
                end else begin
                    mem_rdata = rd_word.w;
                end
            end
            OP_LB: begin
                mem_rdata = {{24{ld_byte[7]}}, ld_byte};
            end
            OP_LBU: begin
                mem_rdata = {24'd0, ld_byte};
            end
            OP_LH: begin
                if (mem_addr[0]) begin
                    adel = 1'b1;
                end else begin
                    mem_rdata = {{16{ld_half[15]}}, ld_half};
                end
            end
            OP_LHU: begin
                if (mem_addr[0]) begin
                    adel = 1'b1;
                end else begin
                    mem_rdata = {16'd0, ld_half};
                end
            end
            OP_SW: begin
                if (mem_addr[1:0] != 2'b00) begin
                    ades = 1'b1;
                end else begin
                    wr_word.w = mem_wdata;
                    sram.wen  = 4'b1111;
                end
            end
            OP_SH: begin
                if (mem_addr[0]) begin
                    ades = 1'b1;
                end else begin
                    // same halfword on both lanes
                    for (int i = 0; i < 2; i++) begin
                        wr_word.h[i] = mem_wdata[15:0];
                    end
                    if (mem_addr[1]) begin
                        sram.wen = 4'b1100;
                    end else begin
                        sram.wen = 4'b0011;
                    end
                end
            end
            OP_SB: begin
                for (int i = 0; i < 4; i++) begin
                    wr_word.b[i] = mem_wdata[7:0];
                end
                sram.wen = 4'b0001 << mem_addr[1:0];
            end
            default: begin
                // not a memory instruction
                sram.wen = 4'b0000;
            end
        endcase
    end

endmodule

/* data_ram.sv */
module data_ram (
    input logic   clk,
    input logic   rst,
    sram_if.slave sram
);
    import mips_mem_pkg::*;

    localparam int DEPTH = 1 << DMEM_AW;

    mem_word_u          mem [0:DEPTH-1];
    mem_word_u          wr_word;
    logic [DMEM_AW-1:0] word_addr;

    // upper address bits are ignored
    assign word_addr = sram.addr[DMEM_AW+1:2];
    assign wr_word   = sram.wdata;

    // async read
    assign sram.rdata = mem[word_addr].w;

    // ##############################
    // byte-lane write
    // ##############################
    // no writes while the pipe is in reset
    always_ff @(posedge clk) begin
        if (sram.en && !rst) begin
            for (int i = 0; i < 4; i++) begin
                if (sram.wen[i]) begin
                    mem[word_addr].b[i] <= wr_word.b[i];
                end
            end
        end
    end

endmodule

/* exc_capture.sv */
module exc_capture (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    input  logic [7:0]                        except_vec,
    input  logic [31:0]                       vaddr,
    input  logic                              clear,
    output logic                              exc_valid,
    output logic [mips_mem_pkg::EXC_CODE_W-1:0] exc_code,
    output logic [31:0]                       bad_vaddr
);
    import mips_mem_pkg::*;

    logic [EXC_CODE_W-1:0] sel_code;
    logic                  data_err;
    logic                  take;

    // highest bit wins
    always_comb begin
        sel_code = EXC_INT;
        data_err = 1'b0;
        if (except_vec[EXC_BIT_INT]) begin
            sel_code = EXC_INT;
        end else if (except_vec[EXC_BIT_IFADEL]) begin
            sel_code = EXC_ADEL;
        end else if (except_vec[EXC_BIT_RI]) begin
            sel_code = EXC_RI;
        end else if (except_vec[EXC_BIT_BRK]) begin
            sel_code = EXC_BP;
        end else if (except_vec[EXC_BIT_SYS]) begin
            sel_code = EXC_SYS;
        end else if (except_vec[EXC_BIT_OV]) begin
            sel_code = EXC_OV;
        end else if (except_vec[EXC_BIT_ADEL]) begin
            sel_code = EXC_ADEL;
            data_err = 1'b1;
        end else if (except_vec[EXC_BIT_ADES]) begin
            sel_code = EXC_ADES;
            data_err = 1'b1;
        end
    end

    // clear beats a new capture
    assign take = valid && (|except_vec) && !exc_valid && !clear && !rst;

    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
            exc_code  <= EXC_INT;
        end else if (clear) begin
            exc_valid <= 1'b0;
        end else if (take) begin
            exc_valid <= 1'b1;
            exc_code  <= sel_code;
        end
    end

    // badvaddr only for data address errors
    always_ff @(posedge clk) begin
        if (take && data_err) begin
            bad_vaddr <= vaddr;
        end
    end

endmodule

/* mem_wb_reg.sv */
module mem_wb_reg (
    input  logic        clk,
    input  logic        rst,
    input  logic        m_valid,
    input  logic [4:0]  m_dest,
    input  logic [31:0] m_data,
    input  logic [7:0]  m_except,
    output logic        wb_valid,
    output logic [4:0]  wb_dest,
    output logic [31:0] wb_data,
    output logic [7:0]  wb_except
);

    logic m_fault;

    assign m_fault = |m_except;

    // ##############################
    // control
    // ##############################
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            wb_except <= 8'd0;
        end else begin
            wb_valid  <= m_valid;
            wb_except <= m_except;
        end
    end

    // ##############################
    // payload
    // ##############################
    // faulting instruction targets $0
    always_ff @(posedge clk) begin
        wb_data <= m_data;
        if (m_fault) begin
            wb_dest <= 5'd0;
        end else begin
            wb_dest <= m_dest;
        end
    end

endmodule

/* mem_stage_top.sv */
module mem_stage_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              m_valid,
    input  logic [5:0]                        op,
    input  logic [31:0]                       addr,
    input  logic [31:0]                       wdata,
    input  logic [4:0]                        dest,
    input  logic [7:0]                        except_in,
    input  logic                              exc_clear,
    output logic                              wb_valid,
    output logic [4:0]                        wb_dest,
    output logic [31:0]                       wb_data,
    output logic [7:0]                        wb_except,
    output logic                              exc_valid,
    output logic [mips_mem_pkg::EXC_CODE_W-1:0] exc_code,
    output logic [31:0]                       bad_vaddr
);

    // merged exceptions and load result of the current instruction
    logic [7:0]  m_except;
    logic [31:0] m_rdata;

    sram_if dmem_bus ();

    // ##############################
    // memory stage
    // ##############################
    mem_access i_mem_access (
        .op         (op),
        .mem_en     (m_valid),
        .mem_wdata  (wdata),
        .mem_addr   (addr),
        .except_in  (except_in),
        .mem_rdata  (m_rdata),
        .except_out (m_except),
        .sram       (dmem_bus.master)
    );

    data_ram i_data_ram (
        .clk  (clk),
        .rst  (rst),
        .sram (dmem_bus.slave)
    );

    // ##############################
    // registered outputs
    // ##############################
    mem_wb_reg i_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .m_valid   (m_valid),
        .m_dest    (dest),
        .m_data    (m_rdata),
        .m_except  (m_except),
        .wb_valid  (wb_valid),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .wb_except (wb_except)
    );

    // first fault and its address
    exc_capture i_exc_capture (
        .clk        (clk),
        .rst        (rst),
        .valid      (m_valid),
        .except_vec (m_except),
        .vaddr      (addr),
        .clear      (exc_clear),
        .exc_valid  (exc_valid),
        .exc_code   (exc_code),
        .bad_vaddr  (bad_vaddr)
    );

endmodule

/* mem_stage_checker.sv */
module mem_stage_checker (
    input logic        clk,
    input logic        rst,
    input logic        sram_en,
    input logic [5:0]  op,
    input logic [31:0] addr,
    input logic [7:0]  except_in,
    input logic        wb_valid,
    input logic [4:0]  wb_dest,
    input logic [7:0]  wb_except,
    input logic        exc_valid,
    input logic        exc_clear
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_mem_pkg::*;

    logic misaligned;

    // word needs addr[1:0] clear, halfword needs addr[0] clear
    always_comb begin
        case (op)
            OP_LW, OP_SW: misaligned = (addr[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: misaligned = addr[0];
            default: misaligned = 1'b0;
        endcase
    end

    // first cycle out of reset
    assert property (@(posedge clk) $fell(rst) |-> (!wb_valid && !exc_valid))
        else $error("wb_valid or exc_valid set right after reset");

    // upstream fault or address error kills the access
    assert property (@(posedge clk) disable iff (rst)
        sram_en |-> ((except_in[7:2] == 6'd0) && !misaligned))
        else $error("sram enabled with upstream vector %h misaligned %b", except_in, misaligned);

    assert property (@(posedge clk) disable iff (rst) (wb_except != 8'd0) |-> (wb_dest == 5'd0))
        else $error("faulting instruction targets register %0d", wb_dest);

    // only a clear drops the held cause
    assert property (@(posedge clk) disable iff (rst) $fell(exc_valid) |-> $past(exc_clear))
        else $error("exc_valid fell without exc_clear");

endmodule

bind mem_stage_top mem_stage_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .sram_en   (dmem_bus.en),
    .op        (op),
    .addr      (addr),
    .except_in (except_in),
    .wb_valid  (wb_valid),
    .wb_dest   (wb_dest),
    .wb_except (wb_except),
    .exc_valid (exc_valid),
    .exc_clear (exc_clear)
);

/* mem_stage_tb.sv */
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_mem_pkg::*;

    localparam int MAXN = 256;

    logic        clk;
    logic        rst;
    logic        m_valid;
    logic [5:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  dest;
    logic [7:0]  except_in;
    logic        exc_clear;
    logic        wb_valid;
    logic [4:0]  wb_dest;
    logic [31:0] wb_data;
    logic [7:0]  wb_except;
    logic        exc_valid;
    logic [4:0]  exc_code;
    logic [31:0] bad_vaddr;

    // one row per cycle, inputs then expected outputs
    int          t_test [MAXN];
    logic [5:0]  t_op [MAXN];
    logic [31:0] t_addr [MAXN];
    logic [31:0] t_wdata [MAXN];
    logic [4:0]  t_dest [MAXN];
    logic [7:0]  t_exc [MAXN];
    logic        t_clr [MAXN];
    logic [31:0] x_data [MAXN];
    logic [4:0]  x_dest [MAXN];
    logic [7:0]  x_except [MAXN];
    logic        x_valid [MAXN];
    logic [4:0]  x_code [MAXN];
    logic [31:0] x_bad [MAXN];
    logic        x_known [MAXN];
    string       test_name [7];

    // reference model state
    logic [31:0] shadow [1 << DMEM_AW];
    logic        cap_valid = 1'b0;
    logic [4:0]  cap_code;
    logic [31:0] cap_bad;
    logic        bad_known = 1'b0;
    logic [31:0] rng = 32'h6f37;

    int          n_entries = 0;
    int          errors = 0;
    int          test_errs = 0;
    bit          table_ready = 1'b0;

    mem_stage_top i_mem_stage_top (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // depends on every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    // cp0 priority, interrupt first
    function automatic logic [4:0] cause_code(input logic [7:0] v);
        if (v[7]) return EXC_INT;
        if (v[6]) return EXC_ADEL;
        if (v[5]) return EXC_RI;
        if (v[4]) return EXC_BP;
        if (v[3]) return EXC_SYS;
        if (v[2]) return EXC_OV;
        if (v[1]) return EXC_ADEL;
        return EXC_ADES;
    endfunction

    task automatic add_entry(input int tst, input logic [5:0] e_op, input logic [31:0] e_addr,
                             input logic [31:0] e_wdata, input logic [4:0] e_dest,
                             input logic [7:0] e_exc, input logic e_clr);
        logic [DMEM_AW-1:0] idx;
        logic [31:0]        word;
        logic [31:0]        data;
        logic [7:0]         vec;
        logic               is_load;
        logic               is_store;
        logic               bad_align;
        int                 sh;
        idx = e_addr[DMEM_AW+1:2];
        word = shadow[idx];
        sh = 8 * e_addr[1:0];
        is_load = e_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
        is_store = e_op inside {OP_SB, OP_SH, OP_SW};
        case (e_op)
            OP_LW, OP_SW: bad_align = (e_addr[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: bad_align = e_addr[0];
            default: bad_align = 1'b0;
        endcase
        vec = {e_exc[7:2], is_load && bad_align, is_store && bad_align};
        data = 32'd0;
        if (is_load && !bad_align) begin
            case (e_op)
                OP_LW: data = word;
                OP_LB: data = {{24{word[sh+7]}}, word[sh +: 8]};
                OP_LBU: data = {24'd0, word[sh +: 8]};
                OP_LH: data = {{16{word[sh+15]}}, word[sh +: 16]};
                default: data = {16'd0, word[sh +: 16]};
            endcase
        end
        if (is_store && vec == 8'd0) begin
            case (e_op)
                OP_SW: shadow[idx] = e_wdata;
                OP_SH: shadow[idx][sh +: 16] = e_wdata[15:0];
                default: shadow[idx][sh +: 8] = e_wdata[7:0];
            endcase
        end
        if (e_clr) begin
            cap_valid = 1'b0;
        end else if (!cap_valid && vec != 8'd0) begin
            cap_valid = 1'b1;
            cap_code = cause_code(vec);
            if (vec[7:2] == 6'd0) begin
                cap_bad = e_addr;
                bad_known = 1'b1;
            end
        end
        t_test[n_entries] = tst;
        t_op[n_entries] = e_op;
        t_addr[n_entries] = e_addr;
        t_wdata[n_entries] = e_wdata;
        t_dest[n_entries] = e_dest;
        t_exc[n_entries] = e_exc;
        t_clr[n_entries] = e_clr;
        x_data[n_entries] = data;
        x_dest[n_entries] = (vec != 8'd0) ? 5'd0 : e_dest;
        x_except[n_entries] = vec;
        x_valid[n_entries] = cap_valid;
        x_code[n_entries] = cap_code;
        x_bad[n_entries] = cap_bad;
        x_known[n_entries] = bad_known;
        n_entries++;
    endtask

    // ##############################
    // stimulus table
    // ##############################
    task automatic build_table;
        logic [31:0] a;
        test_name = '{"word store and load", "byte and halfword stores", "load extension",
                      "misalignment", "upstream exceptions", "exception capture", "random words"};
        for (int i = 0; i < 32; i++) begin
            a = 32'h1000_0000 + (i << 2);
            add_entry(0, OP_SW, a, fill_word(a), 5'd1, 8'h00, 1'b0);
        end
        for (int i = 0; i < 32; i++) begin
            add_entry(0, OP_LW, 32'h1000_0000 + (i << 2), 32'd0, i[4:0], 8'h00, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(1, OP_SB, 32'h1000_0010 + i, 32'h0000_01c0 + i, 5'd2, 8'h00, 1'b0);
            add_entry(1, OP_LW, 32'h1000_0010, 32'd0, 5'd2, 8'h00, 1'b0);
        end
        for (int i = 0; i < 4; i += 2) begin
            add_entry(1, OP_SH, 32'h1000_0010 + i, 32'h7777_9a5b + i, 5'd2, 8'h00, 1'b0);
            add_entry(1, OP_LW, 32'h1000_0010, 32'd0, 5'd2, 8'h00, 1'b0);
        end
        // lanes with the top bit set and clear
        for (int w = 0; w < 2; w++) begin
            a = (w == 0) ? 32'h807f_ff01 : 32'h7f80_01fe;
            add_entry(2, OP_SW, 32'h1000_0020, a, 5'd3, 8'h00, 1'b0);
            for (int i = 0; i < 4; i++) begin
                add_entry(2, OP_LB, 32'h1000_0020 + i, 32'd0, 5'd3, 8'h00, 1'b0);
                add_entry(2, OP_LBU, 32'h1000_0020 + i, 32'd0, 5'd4, 8'h00, 1'b0);
            end
            for (int i = 0; i < 4; i += 2) begin
                add_entry(2, OP_LH, 32'h1000_0020 + i, 32'd0, 5'd5, 8'h00, 1'b0);
                add_entry(2, OP_LHU, 32'h1000_0020 + i, 32'd0, 5'd6, 8'h00, 1'b0);
            end
        end
        for (int i = 1; i < 4; i++) begin
            add_entry(3, OP_LW, 32'h2000_0024 + i, 32'd0, 5'd7, 8'h00, 1'b0);
            add_entry(3, OP_SW, 32'h2000_0024 + i, 32'hdead_beef, 5'd7, 8'h00, 1'b0);
        end
        for (int i = 1; i < 4; i += 2) begin
            add_entry(3, OP_LH, 32'h2000_0024 + i, 32'd0, 5'd8, 8'h00, 1'b0);
            add_entry(3, OP_LHU, 32'h2000_0024 + i, 32'd0, 5'd8, 8'h00, 1'b0);
            add_entry(3, OP_SH, 32'h2000_0024 + i, 32'h0000_beef, 5'd8, 8'h00, 1'b0);
        end
        add_entry(3, OP_LW, 32'h2000_0024, 32'd0, 5'd9, 8'h00, 1'b0);
        add_entry(4, OP_SW, 32'h1000_0028, 32'h1234_5678, 5'd10, 8'h20, 1'b0);
        add_entry(4, OP_SB, 32'h1000_0029, 32'h0000_00aa, 5'd10, 8'h04, 1'b0);
        add_entry(4, OP_LW, 32'h1000_0028, 32'd0, 5'd10, 8'h00, 1'b0);
        add_entry(4, 6'h00, 32'h1000_0028, 32'hffff_ffff, 5'd11, 8'h00, 1'b0);
        add_entry(4, 6'h0f, 32'h1000_0028, 32'hffff_ffff, 5'd11, 8'h08, 1'b0);
        add_entry(5, 6'h00, 32'h0, 32'd0, 5'd12, 8'h00, 1'b1);
        add_entry(5, OP_SW, 32'h1000_002c, 32'h1, 5'd12, 8'h0c, 1'b0);
        add_entry(5, OP_LW, 32'h3000_0031, 32'd0, 5'd12, 8'h00, 1'b0);
        add_entry(5, 6'h00, 32'h0, 32'd0, 5'd12, 8'h00, 1'b1);
        add_entry(5, OP_LH, 32'h3000_0033, 32'd0, 5'd13, 8'h00, 1'b0);
        add_entry(5, 6'h00, 32'h0, 32'd0, 5'd13, 8'h20, 1'b0);
        // clear and a new fault in one cycle
        add_entry(5, OP_SH, 32'h4000_0011, 32'h5555, 5'd14, 8'h00, 1'b1);
        add_entry(5, OP_SH, 32'h4000_0011, 32'h5555, 5'd14, 8'h00, 1'b0);
        add_entry(5, 6'h00, 32'h0, 32'd0, 5'd14, 8'h00, 1'b1);
        add_entry(5, 6'h00, 32'h5000_0000, 32'd0, 5'd15, 8'ha0, 1'b0);
        add_entry(5, OP_LW, 32'h1000_0030, 32'd0, 5'd15, 8'h00, 1'b0);
        for (int i = 0; i < 48; i++) begin
            rng = lcg_next(rng);
            a = {rng[31:10], 3'b000, rng[8:4], 2'b00};
            add_entry(6, rng[2] ? OP_SW : OP_LW, a, {rng[15:0], rng[31:16]}, rng[13:9],
                      8'h00, 1'b0);
        end
    endtask

    task automatic report_mismatch(input int k, input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR %0d ns entry %0d: %s got %h expected %h", $time, k, what, got, exp);
        errors++;
        test_errs++;
    endtask

    task automatic check_entry(input int k);
        if (wb_valid !== 1'b1) report_mismatch(k, "wb_valid", {31'd0, wb_valid}, 32'd1);
        if (wb_data !== x_data[k]) report_mismatch(k, "wb_data", wb_data, x_data[k]);
        if (wb_dest !== x_dest[k])
            report_mismatch(k, "wb_dest", {27'd0, wb_dest}, {27'd0, x_dest[k]});
        if (wb_except !== x_except[k])
            report_mismatch(k, "wb_except", {24'd0, wb_except}, {24'd0, x_except[k]});
        if (exc_valid !== x_valid[k])
            report_mismatch(k, "exc_valid", {31'd0, exc_valid}, {31'd0, x_valid[k]});
        if (x_valid[k] && exc_code !== x_code[k])
            report_mismatch(k, "exc_code", {27'd0, exc_code}, {27'd0, x_code[k]});
        if (x_known[k] && bad_vaddr !== x_bad[k])
            report_mismatch(k, "bad_vaddr", bad_vaddr, x_bad[k]);
        if (k == n_entries - 1 || t_test[k + 1] != t_test[k]) begin
            $display("test %0d %s: %0d errors", t_test[k], test_name[t_test[k]], test_errs);
            test_errs = 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        m_valid = 1'b0;
        op = 6'd0;
        addr = 32'd0;
        wdata = 32'd0;
        dest = 5'd0;
        except_in = 8'd0;
        exc_clear = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < n_entries; k++) begin
            m_valid = 1'b1;
            op = t_op[k];
            addr = t_addr[k];
            wdata = t_wdata[k];
            dest = t_dest[k];
            except_in = t_exc[k];
            exc_clear = t_clr[k];
            @(posedge clk);
            #1;
            check_entry(k);
        end
        m_valid = 1'b0;
        exc_clear = 1'b0;
        $display("entries: %0d, errors: %0d", n_entries, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #((n_entries + 20) * 8);
        $display("the run timed out after %0d cycles", n_entries + 20);
        $display("Test failed");
        $finish;
    end

endmodule

/* mips_mem.f */
mips_mem_pkg.sv
sram_if.sv
mem_access.sv
data_ram.sv
exc_capture.sv
mem_wb_reg.sv
mem_stage_top.sv
mem_stage_checker.sv
mem_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mem_stage_tb -f mips_mem.f -o mem_stage_sim

./obj_dir/mem_stage_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
